// ==== Bender.yml ====
package:
  name: control_unit

sources:
  - include_dirs:
      - common
    files:
      - common/isaPkg.sv
      - common/controlPkg.sv
      - controlUnit/instructionDecoder.sv
      - controlUnit/stepSequencer.sv
      - controlUnit/controlWordTable.sv
      - controlUnit/controlUnit.sv
  - target: test
    include_dirs:
      - common
    files:
      - test/controlUnitTb.sv

// ==== build.f ====
+incdir+common
common/isaPkg.sv
common/controlPkg.sv
controlUnit/instructionDecoder.sv
controlUnit/stepSequencer.sv
controlUnit/controlWordTable.sv
controlUnit/controlUnit.sv
test/controlUnitTb.sv

// ==== common/controlPkg.sv ====
package controlPkg;

    typedef enum logic [3:0] {
        stateReset,
        stateFetch,
        stateAdd,
        stateAddi,
        stateBeq,
        stateBne,
        stateBle,
        stateBgt,
        stateIllegal
    } controlStateT;

    typedef enum logic {
        srcPc   = 1'b0,
        srcRegA = 1'b1
    } aluSrcAT;

    typedef enum logic [1:0] {
        srcRegB      = 2'd0,
        srcFour      = 2'd1,
        srcImmediate = 2'd2
    } aluSrcBT;

    typedef enum logic {
        dstRt = 1'b0,
        dstRd = 1'b1
    } regDstT;

    typedef enum logic {
        pcAluResult    = 1'b0,
        pcBranchTarget = 1'b1
    } pcSrcT;

    // Selects which ALU flag condition qualifies pcWriteCond
    typedef enum logic [2:0] {
        condNone,
        condEq,
        condNe,
        condLe,
        condGt
    } branchCondT;

    typedef struct packed {
        logic              pcWrite;
        logic              pcWriteCond;
        logic              irWrite;
        logic              abWrite;
        logic              aluOutWrite;
        logic              regWrite;
        logic              opcodeError;
        logic              resetOut;
        aluSrcAT           aluSrcA;
        aluSrcBT           aluSrcB;
        isaPkg::aluOpT     aluOp;
        regDstT            regDst;
        pcSrcT             pcSrc;
        branchCondT        branchCond;
    } controlWordT;

endpackage

// ==== common/controlUnit_params.svh ====
`ifndef CONTROL_UNIT_PARAMS_SVH
`define CONTROL_UNIT_PARAMS_SVH

// Instruction field widths
`define CU_OPCODE_WIDTH 6
`define CU_FUNCT_WIDTH 6

// Step counter and sequence lengths
`define CU_STEP_WIDTH 3
`define CU_FETCH_STEPS 6

// Execute lengths in cycles
`define CU_ALU_EXEC_STEPS 2
`define CU_SHORT_EXEC_STEPS 1

// Fetch step that loads the IR and advances the PC
`define CU_IR_LOAD_STEP 3

`endif

// ==== common/isaPkg.sv ====
`include "controlUnit_params.svh"

package isaPkg;

    // Primary opcode field
    typedef enum logic [`CU_OPCODE_WIDTH-1:0] {
        opRType = 6'h00,
        opBeq   = 6'h04,
        opBne   = 6'h05,
        opBle   = 6'h06,
        opBgt   = 6'h07,
        opAddi  = 6'h08,
        opReset = 6'h3F
    } opcodeT;

    // R-type function field, only add is supported
    typedef enum logic [`CU_FUNCT_WIDTH-1:0] {
        functAdd = 6'h20
    } functT;

    typedef enum logic [2:0] {
        instrAdd,
        instrAddi,
        instrBeq,
        instrBne,
        instrBle,
        instrBgt,
        instrReset,
        instrIllegal
    } instrT;

    // Branches compare by subtraction
    typedef enum logic {
        aluAdd = 1'b0,
        aluSub = 1'b1
    } aluOpT;

endpackage

// ==== controlUnit/controlUnit.sv ====
`timescale 1ns/1ps
`include "controlUnit_params.svh"

module controlUnit (
    input  logic                    clock,
    input  logic                    reset,
    input  isaPkg::opcodeT          opcode,
    input  isaPkg::functT           funct,
    output controlPkg::controlWordT control
);
    import isaPkg::*;
    import controlPkg::*;

    instrT                      instr;
    controlStateT               state;
    logic [`CU_STEP_WIDTH-1:0]  step;

    instructionDecoder uDecoder (
        .opcode (opcode),
        .funct  (funct),
        .instr  (instr)
    );

    stepSequencer uSequencer (
        .clock  (clock),
        .reset  (reset),
        .instr  (instr),
        .state  (state),
        .step   (step)
    );

    // Word is combinational from the registered state and step
    controlWordTable uWordTable (
        .state   (state),
        .step    (step),
        .control (control)
    );

endmodule

// ==== controlUnit/controlWordTable.sv ====
`timescale 1ns/1ps
`include "controlUnit_params.svh"

module controlWordTable (
    input  controlPkg::controlStateT    state,
    input  logic [`CU_STEP_WIDTH-1:0]   step,
    output controlPkg::controlWordT     control
);
    import isaPkg::*;
    import controlPkg::*;

    localparam logic [`CU_STEP_WIDTH-1:0] irLoadStep  = `CU_IR_LOAD_STEP;
    localparam logic [`CU_STEP_WIDTH-1:0] operandStep = `CU_IR_LOAD_STEP + 1;

    localparam controlWordT idleWord = '{
        pcWrite:     1'b0,
        pcWriteCond: 1'b0,
        irWrite:     1'b0,
        abWrite:     1'b0,
        aluOutWrite: 1'b0,
        regWrite:    1'b0,
        opcodeError: 1'b0,
        resetOut:    1'b0,
        aluSrcA:     srcPc,
        aluSrcB:     srcRegB,
        aluOp:       aluAdd,
        regDst:      dstRt,
        pcSrc:       pcAluResult,
        branchCond:  condNone
    };

    always_comb begin
        control = idleWord;
        case (state)
            stateReset: begin
                control.resetOut = 1'b1;
            end
            stateFetch: begin
                // PC + 4 runs until the IR is loaded
                if (step <= irLoadStep) begin
                    control.aluSrcB = srcFour;
                end
                if (step == irLoadStep) begin
                    control.pcWrite = 1'b1;
                    control.irWrite = 1'b1;
                end
                if (step == operandStep) begin
                    control.abWrite = 1'b1;
                end
            end
            stateAdd, stateAddi: begin
                if (step == '0) begin
                    control.aluSrcA     = srcRegA;
                    control.aluOutWrite = 1'b1;
                    if (state == stateAddi) begin
                        control.aluSrcB = srcImmediate;
                    end
                end else begin
                    control.regWrite = 1'b1;
                    control.regDst   = (state == stateAdd) ? dstRd : dstRt;
                end
            end
            stateBeq, stateBne, stateBle, stateBgt: begin
                control.aluSrcA     = srcRegA;
                control.aluOp       = aluSub;
                control.pcWriteCond = 1'b1;
                control.pcSrc       = pcBranchTarget;
                case (state)
                    stateBeq: control.branchCond = condEq;
                    stateBne: control.branchCond = condNe;
                    stateBle: control.branchCond = condLe;
                    default:  control.branchCond = condGt;
                endcase
            end
            stateIllegal: begin
                control.opcodeError = 1'b1;
            end
            default: begin
                control = idleWord;
            end
        endcase
    end

endmodule

// ==== controlUnit/instructionDecoder.sv ====
`timescale 1ns/1ps

module instructionDecoder (
    input  isaPkg::opcodeT opcode,
    input  isaPkg::functT  funct,
    output isaPkg::instrT  instr
);
    import isaPkg::*;

    always_comb begin
        case (opcode)
            opRType: begin
                // Only add among the R-type functions
                if (funct == functAdd) begin
                    instr = instrAdd;
                end else begin
                    instr = instrIllegal;
                end
            end
            opAddi: begin
                instr = instrAddi;
            end
            opBeq: begin
                instr = instrBeq;
            end
            opBne: begin
                instr = instrBne;
            end
            opBle: begin
                instr = instrBle;
            end
            opBgt: begin
                instr = instrBgt;
            end
            opReset: begin
                instr = instrReset;
            end
            default: begin
                instr = instrIllegal;
            end
        endcase
    end

endmodule

// ==== controlUnit/stepSequencer.sv ====
`timescale 1ns/1ps
`include "controlUnit_params.svh"

module stepSequencer (
    input  logic                        clock,
    input  logic                        reset,
    input  isaPkg::instrT               instr,
    output controlPkg::controlStateT    state,
    output logic [`CU_STEP_WIDTH-1:0]   step
);
    import isaPkg::*;
    import controlPkg::*;

    localparam logic [`CU_STEP_WIDTH-1:0] lastFetchStep = `CU_FETCH_STEPS - 1;

    controlStateT nextState;
    logic [`CU_STEP_WIDTH-1:0] nextStep;

    // Number of execute cycles spent in each non-fetch state
    function automatic logic [`CU_STEP_WIDTH-1:0] execSteps(input controlStateT s);
        case (s)
            stateAdd, stateAddi: begin
                return `CU_ALU_EXEC_STEPS;
            end
            default: begin
                return `CU_SHORT_EXEC_STEPS;
            end
        endcase
    endfunction

    function automatic controlStateT decodeTarget(input instrT i);
        case (i)
            instrAdd:   return stateAdd;
            instrAddi:  return stateAddi;
            instrBeq:   return stateBeq;
            instrBne:   return stateBne;
            instrBle:   return stateBle;
            instrBgt:   return stateBgt;
            instrReset: return stateReset;
            default:    return stateIllegal;
        endcase
    endfunction

    always_comb begin
        nextState = state;
        nextStep  = step + 1'b1;
        if (state == stateFetch) begin
            // Decode step, branch on the instruction
            if (step == lastFetchStep) begin
                nextState = decodeTarget(instr);
                nextStep  = '0;
            end
        end else if (step == execSteps(state) - 1'b1) begin
            nextState = stateFetch;
            nextStep  = '0;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= stateReset;
            step  <= '0;
        end else begin
            state <= nextState;
            step  <= nextStep;
        end
    end

endmodule

// ==== test/controlUnitStim.txt ====
# opcode(hex) funct(hex) instr latency
# instr codes 0 add 1 addi 2 beq 3 bne 4 ble 5 bgt 6 reset 7 illegal
00 20 0 8
08 00 1 8
04 00 2 7
05 00 3 7
06 00 4 7
07 00 5 7
3f 00 6 7
00 22 7 7
02 00 7 7
00 20 0 8
3f 15 6 7
08 3f 1 8
23 00 7 7
04 11 2 7
00 00 7 7
07 20 5 7
3e 20 7 7
06 3f 4 7
05 20 3 7
00 20 0 8

// ==== test/controlUnitTb.sv ====
`timescale 1ns/1ps
`include "controlUnit_params.svh"

module controlUnitTb;
    import isaPkg::*;
    import controlPkg::*;

    typedef struct packed {
        opcodeT opcode;
        functT  funct;
        instrT  instr;
        int     latency;
    } stimEntryT;

    localparam controlWordT idleWord = '{
        pcWrite: 1'b0, pcWriteCond: 1'b0, irWrite: 1'b0, abWrite: 1'b0,
        aluOutWrite: 1'b0, regWrite: 1'b0, opcodeError: 1'b0, resetOut: 1'b0,
        aluSrcA: srcPc, aluSrcB: srcRegB, aluOp: aluAdd,
        regDst: dstRt, pcSrc: pcAluResult, branchCond: condNone
    };

    logic        clock;
    logic        reset;
    opcodeT      opcode;
    functT       funct;
    controlWordT control;

    stimEntryT entries[$];
    int cycleCount = 0;
    int cycleLimit = 0;
    int cycleIndex = 0;
    int lastIrCycle = 0;
    int irCount = 0;

    controlUnit u_dut (
        .clock   (clock),
        .reset   (reset),
        .opcode  (opcode),
        .funct   (funct),
        .control (control)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("Simulation FAILED");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic checkControl(input string testName, input controlWordT expected,
                                input controlWordT actual);
        if (actual !== expected) begin
            failRun($sformatf("Error %s: expected %h, actual %h", testName, expected, actual));
        end
    endtask

    task automatic checkLatency(input string testName, input int expected, input int actual);
        if (actual != expected) begin
            failRun($sformatf("Error %s: expected %0d, actual %0d", testName, expected, actual));
        end
    endtask

    function automatic int execLength(input instrT instr);
        return (instr == instrAdd || instr == instrAddi) ? 2 : 1;
    endfunction

    // Step counts through fetch first, execute steps follow at CU_FETCH_STEPS
    function automatic controlWordT expectedWord(input instrT instr, input int step);
        controlWordT w;
        w = idleWord;
        if (step < `CU_FETCH_STEPS) begin
            w.aluSrcB = (step <= 3) ? srcFour : srcRegB;
            w.pcWrite = (step == 3);
            w.irWrite = (step == 3);
            w.abWrite = (step == 4);
        end else begin
            case (instr)
                instrAdd, instrAddi: begin
                    if (step == `CU_FETCH_STEPS) begin
                        w.aluSrcA     = srcRegA;
                        w.aluOutWrite = 1'b1;
                        w.aluSrcB     = (instr == instrAddi) ? srcImmediate : srcRegB;
                    end else begin
                        w.regWrite = 1'b1;
                        w.regDst   = (instr == instrAdd) ? dstRd : dstRt;
                    end
                end
                instrBeq, instrBne, instrBle, instrBgt: begin
                    w.aluSrcA     = srcRegA;
                    w.aluOp       = aluSub;
                    w.pcWriteCond = 1'b1;
                    w.pcSrc       = pcBranchTarget;
                    case (instr)
                        instrBeq: w.branchCond = condEq;
                        instrBne: w.branchCond = condNe;
                        instrBle: w.branchCond = condLe;
                        default:  w.branchCond = condGt;
                    endcase
                end
                instrReset: w.resetOut = 1'b1;
                default:    w.opcodeError = 1'b1;
            endcase
        end
        return w;
    endfunction

    task automatic loadStimulus();
        int fd;
        int fields;
        int rawOpcode;
        int rawFunct;
        int rawInstr;
        int latency;
        string line;
        stimEntryT entry;
        fd = $fopen("test/controlUnitStim.txt", "r");
        if (fd == 0) begin
            failRun("Could not open the stimulus file test/controlUnitStim.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            fields = $sscanf(line, "%h %h %d %d", rawOpcode, rawFunct, rawInstr, latency);
            if (fields != 4) begin
                failRun({"Malformed stimulus line: ", line});
            end
            entry.opcode  = opcodeT'(rawOpcode[`CU_OPCODE_WIDTH-1:0]);
            entry.funct   = functT'(rawFunct[`CU_FUNCT_WIDTH-1:0]);
            entry.instr   = instrT'(rawInstr[2:0]);
            entry.latency = latency;
            entries.push_back(entry);
        end
        $fclose(fd);
        if (entries.size() == 0) begin
            failRun("The stimulus file holds no instructions");
        end
    endtask

    // Word is stable at the falling edge
    task automatic checkCycle(input string testName, input controlWordT expected);
        @(negedge clock);
        cycleIndex++;
        // IR load spacing is measured on the DUT's own irWrite pulses
        if (control.irWrite) begin
            if (irCount > 0) begin
                checkLatency($sformatf("latency of entry %0d", irCount - 1),
                             entries[irCount - 1].latency, cycleIndex - lastIrCycle);
            end
            irCount++;
            lastIrCycle = cycleIndex;
        end
        checkControl(testName, expected, control);
    endtask

    always @(posedge clock) begin
        cycleCount = cycleCount + 1;
        if (cycleLimit > 0 && cycleCount > cycleLimit) begin
            failRun($sformatf("Timeout: the run did not finish within %0d cycles", cycleLimit));
        end
    end

    initial begin
        stimEntryT entry;
        instrT instr;
        int steps;
        reset  = 1'b1;
        opcode = opRType;
        funct  = functAdd;
        loadStimulus();
        cycleLimit = 10 * entries.size() + 20;

        // Last cycle has reset low but still shows the registered reset state
        for (int c = 0; c < 4; c++) begin
            @(posedge clock);
            #1;
            if (c == 3) begin
                reset = 1'b0;
            end
            checkCycle($sformatf("reset cycle %0d", c),
                       expectedWord(instrReset, `CU_FETCH_STEPS));
        end

        foreach (entries[n]) begin
            entry = entries[n];
            instr = entry.instr;
            steps = `CU_FETCH_STEPS + execLength(instr);
            for (int c = 0; c < steps; c++) begin
                @(posedge clock);
                #1;
                if (c == 0) begin
                    opcode = entry.opcode;
                    funct  = entry.funct;
                end
                checkCycle($sformatf("entry %0d %s step %0d", n, instr.name(), c),
                           expectedWord(instr, c));
            end
        end

        // One more IR load closes the last latency
        for (int c = 0; c <= 3; c++) begin
            @(posedge clock);
            #1;
            checkCycle($sformatf("final fetch step %0d", c), expectedWord(instrAdd, c));
        end

        if (irCount != entries.size() + 1) begin
            failRun($sformatf("Saw %0d IR loads where %0d were expected",
                              irCount, entries.size() + 1));
        end else begin
            $display("Simulation PASSED");
            $finish;
        end
    end

endmodule
